//--- axi_line_pkg.sv
package axi_line_pkg;

   // Byte address width on both the core and the L2 side
   localparam int ADDR_W = 32;

   // Byte address of a beat or of a line
   typedef logic [ADDR_W-1:0] addr_t;

   // Size code holds log2 of the bytes moved per beat
   typedef logic [2:0] size_t;

   // Length code holds the number of beats minus one
   typedef logic [7:0] len_t;

endpackage

//--- line_fsm_pkg.sv
package line_fsm_pkg;

   // Write controller states
   typedef enum logic [2:0] {
      write_idle,
      write_gather,
      write_send,
      write_send_data,
      write_wait_l2,
      write_respond
   } write_state_t;

   // Read controller states
   typedef enum logic [1:0] {
      read_idle,
      read_request,
      read_wait_data,
      read_beat_out
   } read_state_t;

endpackage

//--- write_gather.sv
module write_gather #(
   parameter int LINE_LOG2 = 6
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          awvalid,
   output logic                          awready,
   input  axi_line_pkg::addr_t           awaddr,
   input  axi_line_pkg::size_t           awsize,
   input  axi_line_pkg::len_t            awlen,
   input  logic                          wvalid,
   output logic                          wready,
   input  logic [(8 << LINE_LOG2)-1:0]   wdata,
   input  logic [(1 << LINE_LOG2)-1:0]   wstrb,
   input  logic                          wlast,
   output logic                          bvalid,
   input  logic                          bready,
   output logic                          l2_awvalid,
   input  logic                          l2_awready,
   output axi_line_pkg::addr_t           l2_awaddr,
   output logic                          l2_wvalid,
   input  logic                          l2_wready,
   output logic [(8 << LINE_LOG2)-1:0]   l2_wdata,
   output logic [(1 << LINE_LOG2)-1:0]   l2_wstrb,
   input  logic                          l2_bvalid,
   output logic                          l2_bready
);
   import axi_line_pkg::*;
   import line_fsm_pkg::*;

   localparam int DATA_W = 8 << LINE_LOG2;
   localparam int STRB_W = 1 << LINE_LOG2;

   write_state_t         state;
   write_state_t         state_next;
   addr_t                wr_addr;
   addr_t                addr_next;
   size_t                wr_size;
   len_t                 wr_len;
   logic [LINE_LOG2:0]   beat_bytes;
   logic [LINE_LOG2-1:0] ofs;
   logic [STRB_W-1:0]    lane_mask;
   logic [STRB_W-1:0]    place_strb;
   logic [STRB_W-1:0]    line_strb;
   logic [DATA_W-1:0]    place_data;
   logic [DATA_W-1:0]    line_data;
   logic                 beat_fire;
   logic                 beat_last;
   logic                 line_close;
   logic                 last_line;
   logic                 w_sent;

   // Idle advertises wready but withdraws it if a beat shows up before its address
   assign awready = (state == write_idle);
   assign wready  = (state == write_gather) | ((state == write_idle) & ~wvalid);
   assign bvalid  = (state == write_respond);

   assign beat_fire  = wvalid & wready;
   assign beat_bytes = {{LINE_LOG2{1'b0}}, 1'b1} << wr_size;
   assign addr_next  = wr_addr + addr_t'(beat_bytes);
   assign beat_last  = wlast | (wr_len == '0);

   // The line closes on the last beat or when the next beat falls in another line
   assign line_close = beat_last |
                       (addr_next[ADDR_W-1:LINE_LOG2] != wr_addr[ADDR_W-1:LINE_LOG2]);

   // A narrow beat sits in the low lanes and is shifted to its place in the line
   assign ofs        = wr_addr[LINE_LOG2-1:0];
   assign lane_mask  = ~({STRB_W{1'b1}} << beat_bytes);
   assign place_strb = (wstrb & lane_mask) << ofs;
   assign place_data = wdata << {ofs, 3'b000};

   assign l2_awvalid = (state == write_send);
   assign l2_wvalid  = ((state == write_send) & ~w_sent) | (state == write_send_data);
   assign l2_wdata   = line_data;
   assign l2_wstrb   = line_strb;
   assign l2_bready  = 1'b1;

   always_comb begin
      state_next = state;
      case (state)
         write_idle: begin
            if (awvalid) state_next = write_gather;
         end
         write_gather: begin
            if (beat_fire & line_close) state_next = write_send;
         end
         write_send: begin
            // Data may go ahead of the address and is then remembered in w_sent
            if (l2_awready) begin
               if (l2_wready | w_sent) state_next = write_wait_l2;
               else state_next = write_send_data;
            end
         end
         write_send_data: begin
            if (l2_wready) state_next = write_wait_l2;
         end
         write_wait_l2: begin
            if (l2_bvalid) state_next = last_line ? write_respond : write_gather;
         end
         write_respond: begin
            if (bready) state_next = write_idle;
         end
         default: state_next = write_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= write_idle;
         w_sent    <= 1'b0;
         last_line <= 1'b0;
         line_strb <= '0;
      end else begin
         state <= state_next;
         if (state == write_send) w_sent <= w_sent | (l2_wvalid & l2_wready);
         else w_sent <= 1'b0;
         if (beat_fire & line_close) last_line <= beat_last;
         // Strobes restart empty once L2 has taken the line
         if (l2_wvalid & l2_wready) line_strb <= '0;
         else if (beat_fire) line_strb <= line_strb | place_strb;
      end
   end

   always_ff @(posedge clk) begin
      if (awvalid & awready) begin
         wr_addr <= awaddr;
         wr_size <= awsize;
         wr_len  <= awlen;
      end else if (beat_fire) begin
         wr_addr <= addr_next;
         wr_len  <= wr_len - 1'b1;
      end
      if (beat_fire & line_close) begin
         l2_awaddr <= {wr_addr[ADDR_W-1:LINE_LOG2], {LINE_LOG2{1'b0}}};
      end
      if (beat_fire) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (place_strb[i]) line_data[8*i +: 8] <= place_data[8*i +: 8];
         end
      end
   end

endmodule

//--- read_scatter.sv
module read_scatter #(
   parameter int LINE_LOG2 = 6
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          arvalid,
   output logic                          arready,
   input  axi_line_pkg::addr_t           araddr,
   input  axi_line_pkg::size_t           arsize,
   input  axi_line_pkg::len_t            arlen,
   output logic                          rvalid,
   input  logic                          rready,
   output logic [(8 << LINE_LOG2)-1:0]   rdata,
   output logic                          rlast,
   output logic                          l2_arvalid,
   input  logic                          l2_arready,
   output axi_line_pkg::addr_t           l2_araddr,
   input  logic                          l2_rvalid,
   output logic                          l2_rready,
   input  logic [(8 << LINE_LOG2)-1:0]   l2_rdata
);
   import axi_line_pkg::*;
   import line_fsm_pkg::*;

   localparam int DATA_W = 8 << LINE_LOG2;

   read_state_t                 state;
   read_state_t                 state_next;
   logic [ADDR_W-LINE_LOG2-1:0] rd_line;
   logic [LINE_LOG2-1:0]        rd_ofs;
   logic [LINE_LOG2-1:0]        ofs_next;
   logic                        ofs_wrap;
   size_t                       rd_size;
   len_t                        rd_len;
   logic [LINE_LOG2:0]          beat_bytes;
   logic [DATA_W-1:0]           rd_data;
   logic [DATA_W-1:0]           beat_mask;
   logic                        beat_fire;

   assign arready    = (state == read_idle);
   assign l2_arvalid = (state == read_request);
   assign l2_rready  = (state == read_wait_data);
   assign rvalid     = (state == read_beat_out);
   assign rlast      = rvalid & (rd_len == '0);
   assign l2_araddr  = {rd_line, {LINE_LOG2{1'b0}}};

   assign beat_fire  = rvalid & rready;
   assign beat_bytes = {{LINE_LOG2{1'b0}}, 1'b1} << rd_size;

   // A carry out of the offset means the next beat lives in the following line
   assign {ofs_wrap, ofs_next} = {1'b0, rd_ofs} + beat_bytes;

   // The selected beat moves to the low bytes and the lanes above it read as zero
   assign beat_mask = ~({DATA_W{1'b1}} << {beat_bytes, 3'b000});
   assign rdata     = (rd_data >> {rd_ofs, 3'b000}) & beat_mask;

   always_comb begin
      state_next = state;
      case (state)
         read_idle: begin
            if (arvalid) state_next = read_request;
         end
         read_request: begin
            if (l2_arready) state_next = read_wait_data;
         end
         read_wait_data: begin
            if (l2_rvalid) state_next = read_beat_out;
         end
         read_beat_out: begin
            if (rready) begin
               if (rd_len == '0) state_next = read_idle;
               else if (ofs_wrap) state_next = read_request;
            end
         end
         default: state_next = read_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= read_idle;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (arvalid & arready) begin
         rd_line <= araddr[ADDR_W-1:LINE_LOG2];
         rd_ofs  <= araddr[LINE_LOG2-1:0];
         rd_size <= arsize;
         rd_len  <= arlen;
      end else if (beat_fire) begin
         rd_ofs <= ofs_next;
         rd_len <= rd_len - 1'b1;
         // Step to the next line so the following request already has its address
         if (ofs_wrap) rd_line <= rd_line + 1'b1;
      end
      if (l2_rvalid & l2_rready) begin
         rd_data <= l2_rdata;
      end
   end

endmodule

//--- line_adapter.sv
module line_adapter #(
   parameter int LINE_LOG2 = 6
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          awvalid,
   output logic                          awready,
   input  axi_line_pkg::addr_t           awaddr,
   input  axi_line_pkg::size_t           awsize,
   input  axi_line_pkg::len_t            awlen,
   input  logic                          wvalid,
   output logic                          wready,
   input  logic [(8 << LINE_LOG2)-1:0]   wdata,
   input  logic [(1 << LINE_LOG2)-1:0]   wstrb,
   input  logic                          wlast,
   output logic                          bvalid,
   input  logic                          bready,
   input  logic                          arvalid,
   output logic                          arready,
   input  axi_line_pkg::addr_t           araddr,
   input  axi_line_pkg::size_t           arsize,
   input  axi_line_pkg::len_t            arlen,
   output logic                          rvalid,
   input  logic                          rready,
   output logic [(8 << LINE_LOG2)-1:0]   rdata,
   output logic                          rlast,
   output logic                          l2_awvalid,
   input  logic                          l2_awready,
   output axi_line_pkg::addr_t           l2_awaddr,
   output logic                          l2_wvalid,
   input  logic                          l2_wready,
   output logic [(8 << LINE_LOG2)-1:0]   l2_wdata,
   output logic [(1 << LINE_LOG2)-1:0]   l2_wstrb,
   input  logic                          l2_bvalid,
   output logic                          l2_bready,
   output logic                          l2_arvalid,
   input  logic                          l2_arready,
   output axi_line_pkg::addr_t           l2_araddr,
   input  logic                          l2_rvalid,
   output logic                          l2_rready,
   input  logic [(8 << LINE_LOG2)-1:0]   l2_rdata
);

   // Write and read paths share nothing and run side by side
   write_gather #(
      .LINE_LOG2(LINE_LOG2)
   ) u_write_gather (
      .clk        (clk),
      .rstn       (rstn),
      .awvalid    (awvalid),
      .awready    (awready),
      .awaddr     (awaddr),
      .awsize     (awsize),
      .awlen      (awlen),
      .wvalid     (wvalid),
      .wready     (wready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wlast      (wlast),
      .bvalid     (bvalid),
      .bready     (bready),
      .l2_awvalid (l2_awvalid),
      .l2_awready (l2_awready),
      .l2_awaddr  (l2_awaddr),
      .l2_wvalid  (l2_wvalid),
      .l2_wready  (l2_wready),
      .l2_wdata   (l2_wdata),
      .l2_wstrb   (l2_wstrb),
      .l2_bvalid  (l2_bvalid),
      .l2_bready  (l2_bready)
   );

   read_scatter #(
      .LINE_LOG2(LINE_LOG2)
   ) u_read_scatter (
      .clk        (clk),
      .rstn       (rstn),
      .arvalid    (arvalid),
      .arready    (arready),
      .araddr     (araddr),
      .arsize     (arsize),
      .arlen      (arlen),
      .rvalid     (rvalid),
      .rready     (rready),
      .rdata      (rdata),
      .rlast      (rlast),
      .l2_arvalid (l2_arvalid),
      .l2_arready (l2_arready),
      .l2_araddr  (l2_araddr),
      .l2_rvalid  (l2_rvalid),
      .l2_rready  (l2_rready),
      .l2_rdata   (l2_rdata)
   );

endmodule

//--- tb_l2_model.sv
module tb_l2_model #(
   parameter int LINE_LOG2 = 6,
   parameter int SEED      = 32'h1234_5678
) (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic                        l2_awvalid,
   output logic                        l2_awready,
   input  axi_line_pkg::addr_t         l2_awaddr,
   input  logic                        l2_wvalid,
   output logic                        l2_wready,
   input  logic [(8 << LINE_LOG2)-1:0] l2_wdata,
   input  logic [(1 << LINE_LOG2)-1:0] l2_wstrb,
   output logic                        l2_bvalid,
   input  logic                        l2_bready,
   input  logic                        l2_arvalid,
   output logic                        l2_arready,
   input  axi_line_pkg::addr_t         l2_araddr,
   output logic                        l2_rvalid,
   input  logic                        l2_rready,
   output logic [(8 << LINE_LOG2)-1:0] l2_rdata
);
   import axi_line_pkg::*;

   localparam int STRB_W   = 1 << LINE_LOG2;
   localparam int DATA_W   = 8 << LINE_LOG2;
   localparam int MEM_MASK = 4095;

   logic [7:0]        mem [0:MEM_MASK];
   int                seed;
   int                errors;
   logic              aw_fire, w_fire, ar_fire, r_fire;
   logic              got_aw, got_w, rd_pend;
   addr_t             aw_cap, aw_q, ar_cap, ar_q;
   logic [DATA_W-1:0] w_cap, w_q;
   logic [STRB_W-1:0] s_cap, s_q;

   initial begin
      seed   = SEED;
      errors = 0;
      // Every byte gets a value tied to its full address
      for (int i = 0; i <= MEM_MASK; i++) mem[i] = 8'((i * 37) ^ (i >> 4) ^ (i >> 9));
      {l2_awready, l2_wready, l2_arready, l2_bvalid, l2_rvalid} = '0;
      l2_rdata = '0;
      {aw_fire, w_fire, ar_fire, r_fire, got_aw, got_w, rd_pend} = '0;
   end

   // Handshakes are sampled between edges, where every signal is settled
   always @(negedge clk) begin
      aw_fire = l2_awvalid & l2_awready;
      w_fire  = l2_wvalid & l2_wready;
      ar_fire = l2_arvalid & l2_arready;
      r_fire  = l2_rvalid & l2_rready;
      if (aw_fire) aw_cap = l2_awaddr;
      if (ar_fire) ar_cap = l2_araddr;
      if (w_fire) begin
         w_cap = l2_wdata;
         s_cap = l2_wstrb;
      end
   end

   always @(posedge clk) begin
      l2_awready <= ($random(seed) & 3) != 0;
      l2_wready  <= ($random(seed) & 3) != 0;
      l2_arready <= ($random(seed) & 1) != 0;
      l2_bvalid  <= 1'b0;
      if (!rstn) begin
         got_aw    <= 1'b0;
         got_w     <= 1'b0;
         rd_pend   <= 1'b0;
         l2_rvalid <= 1'b0;
      end else begin
         if (got_aw && got_w) begin
            if ($random(seed) & 1) begin
               for (int i = 0; i < STRB_W; i++)
                  if (s_q[i]) mem[(aw_q + i) & MEM_MASK] = w_q[8*i +: 8];
               l2_bvalid <= 1'b1;
               got_aw    <= 1'b0;
               got_w     <= 1'b0;
            end
         end else begin
            if (aw_fire) begin
               got_aw <= 1'b1;
               aw_q   <= aw_cap;
            end
            if (w_fire) begin
               got_w <= 1'b1;
               w_q   <= w_cap;
               s_q   <= s_cap;
            end
         end
         if (ar_fire) begin
            rd_pend <= 1'b1;
            ar_q    <= ar_cap;
         end
         if (l2_rvalid && r_fire) begin
            l2_rvalid <= 1'b0;
         end else if (rd_pend && !l2_rvalid && ($random(seed) & 1)) begin
            for (int i = 0; i < STRB_W; i++) l2_rdata[8*i +: 8] <= mem[(ar_q + i) & MEM_MASK];
            l2_rvalid <= 1'b1;
            rd_pend   <= 1'b0;
         end
      end
   end

   // Every L2 address has to point at the start of a line
   assert property (@(posedge clk) l2_awvalid |-> l2_awaddr[LINE_LOG2-1:0] == '0)
      else begin
         errors++;
         $display("error %0t: l2_awaddr %h is not line aligned", $time, l2_awaddr);
      end
   assert property (@(posedge clk) l2_arvalid |-> l2_araddr[LINE_LOG2-1:0] == '0)
      else begin
         errors++;
         $display("error %0t: l2_araddr %h is not line aligned", $time, l2_araddr);
      end

   // The write response is a single cycle pulse, so the adapter has to take it at once
   assert property (@(posedge clk) disable iff (!rstn) l2_bvalid |-> l2_bready)
      else begin
         errors++;
         $display("error %0t: l2_bvalid offered while l2_bready is low", $time);
      end

endmodule

//--- tb_line_adapter.sv
module tb_line_adapter;
   import axi_line_pkg::*;

   localparam int LINE_LOG2   = 6;
   localparam int DATA_W      = 8 << LINE_LOG2;
   localparam int STRB_W      = 1 << LINE_LOG2;
   localparam int MEM_MASK    = 4095;
   localparam int NUM_RAND    = 20;
   localparam int WATCHDOG_NS = (16 + (NUM_RAND * 2 + 3) * 17 * 40) * 10 * 2;

   logic clk = 1'b0;
   logic rstn = 1'b0;
   logic awvalid = 1'b0, wvalid = 1'b0, wlast = 1'b0, bready = 1'b1;
   logic arvalid = 1'b0, rready = 1'b0;
   addr_t awaddr = '0, araddr = '0;
   size_t awsize = '0, arsize = '0;
   len_t  awlen = '0, arlen = '0;
   logic [DATA_W-1:0] wdata = '0;
   logic [STRB_W-1:0] wstrb = '0;
   logic awready, wready, bvalid, arready, rvalid, rlast;
   logic [DATA_W-1:0] rdata, l2_wdata, l2_rdata;
   logic [STRB_W-1:0] l2_wstrb, last_strb;
   logic l2_awvalid, l2_awready, l2_wvalid, l2_wready, l2_bvalid, l2_bready;
   logic l2_arvalid, l2_arready, l2_rvalid, l2_rready;
   addr_t l2_awaddr, l2_araddr;

   int seed = 32'hcbe7_7c7b;
   int errors = 0;
   int l2_writes = 0, l2_reads = 0, b_count = 0, rd_idx = 0;
   logic [7:0] ref_mem [0:MEM_MASK];
   logic [DATA_W-1:0] exp_data [$];
   logic exp_last [$];

   line_adapter #(.LINE_LOG2(LINE_LOG2)) dut (.*);
   tb_l2_model #(.LINE_LOG2(LINE_LOG2), .SEED(32'hcbe7_7c7b)) u_l2 (.*);

   always #5 clk = ~clk;

   always @(posedge clk) rready <= rstn & (($random(seed) & 3) != 0);

   // Bookkeeping between edges sees the values that the next edge samples
   always @(negedge clk) begin
      if (l2_wvalid && l2_wready) begin
         l2_writes++;
         last_strb = l2_wstrb;
      end
      if (l2_arvalid && l2_arready) l2_reads++;
      if (bvalid && bready) b_count++;
      if (rvalid && rready) begin
         if (rd_idx >= exp_data.size()) begin
            errors++;
            $display("error %0t: read beat arrived with none expected", $time);
         end else begin
            assert (rdata == exp_data[rd_idx] && rlast == exp_last[rd_idx])
               else begin
                  errors++;
                  $display("error %0t: beat %0d rdata %h rlast %b, expected %h %b", $time,
                           rd_idx, rdata, rlast, exp_data[rd_idx], exp_last[rd_idx]);
               end
         end
         rd_idx++;
      end
   end

   assert property (@(posedge clk) $rose(rstn) |-> awready && wready && arready && !bvalid &&
                    !rvalid && !rlast && !l2_awvalid && !l2_wvalid && !l2_arvalid && !l2_rready)
      else begin
         errors++;
         $display("error %0t: outputs after reset are not at their idle values", $time);
      end
   assert property (@(posedge clk) disable iff (!rstn)
                    rvalid && !rready |=> rvalid && $stable(rdata))
      else begin
         errors++;
         $display("error %0t: read beat changed while stalled", $time);
      end

   function automatic int lines_touched(input int addr, input int nb, input int len);
      return ((addr + len * nb) >> LINE_LOG2) - (addr >> LINE_LOG2) + 1;
   endfunction

   task automatic check_count(input string what, input int got, input int want);
      assert (got == want)
         else begin
            errors++;
            $display("error %0t: %s count %0d, expected %0d", $time, what, got, want);
         end
   endtask

   task automatic write_burst(input int addr, input int size, input int len);
      int nb;
      int a;
      int wr0;
      int b0;
      logic [DATA_W-1:0] d;
      @(posedge clk);
      nb  = 1 << size;
      wr0 = l2_writes;
      b0  = b_count;
      awvalid <= 1'b1;
      awaddr  <= addr;
      awsize  <= size;
      awlen   <= len;
      do @(negedge clk); while (!awready);
      @(posedge clk);
      awvalid <= 1'b0;
      for (int k = 0; k <= len; k++) begin
         // Bytes above the beat carry junk that the DUT must ignore
         for (int j = 0; j < DATA_W / 32; j++) d[32*j +: 32] = $random(seed);
         a = addr + k * nb;
         for (int j = 0; j < nb; j++) ref_mem[(a + j) & MEM_MASK] = d[8*j +: 8];
         wvalid <= 1'b1;
         wdata  <= d;
         wstrb  <= '1;
         wlast  <= (k == len);
         do @(negedge clk); while (!wready);
         @(posedge clk);
      end
      wvalid <= 1'b0;
      wlast  <= 1'b0;
      do @(negedge clk); while (!bvalid);
      @(posedge clk);
      @(negedge clk);
      check_count("l2 write", l2_writes - wr0, lines_touched(addr, nb, len));
      check_count("write response", b_count - b0, 1);
   endtask

   task automatic read_burst(input int addr, input int size, input int len);
      int nb;
      int r0;
      logic [DATA_W-1:0] v;
      @(posedge clk);
      nb = 1 << size;
      r0 = l2_reads;
      for (int k = 0; k <= len; k++) begin
         v = '0;
         for (int j = 0; j < nb; j++) v[8*j +: 8] = ref_mem[(addr + k * nb + j) & MEM_MASK];
         exp_data.push_back(v);
         exp_last.push_back(k == len);
      end
      arvalid <= 1'b1;
      araddr  <= addr;
      arsize  <= size;
      arlen   <= len;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      while (rd_idx < exp_data.size()) @(posedge clk);
      @(negedge clk);
      check_count("l2 read", l2_reads - r0, lines_touched(addr, nb, len));
   endtask

   task automatic compare_memory();
      for (int i = 0; i <= MEM_MASK; i++) begin
         assert (u_l2.mem[i] == ref_mem[i])
            else begin
               errors++;
               $display("error %0t: l2 byte %h is %h, expected %h", $time, i, u_l2.mem[i],
                        ref_mem[i]);
            end
      end
   endtask

   initial begin
      #WATCHDOG_NS;
      $display("watchdog expired before the tests finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      int size;
      int len;
      int addr;
      repeat (16) @(posedge clk);
      for (int i = 0; i <= MEM_MASK; i++) ref_mem[i] = u_l2.mem[i];
      rstn <= 1'b1;
      repeat (2) @(posedge clk);
      write_burst(32'h100, LINE_LOG2, 0);
      assert (last_strb == '1)
         else begin
            errors++;
            $display("error %0t: full line write strobes %h", $time, last_strb);
         end
      compare_memory();
      write_burst(32'h130, 2, 7);
      compare_memory();
      read_burst(32'h138, 2, 7);
      for (int n = 0; n < NUM_RAND; n++) begin
         size = ($random(seed) & 32'h7fff_ffff) % 3;
         len  = ($random(seed) & 32'h7fff_ffff) % 16;
         addr = ($random(seed) & 32'h0000_0fc0) | (($random(seed) & 63) & ~((1 << size) - 1));
         write_burst(addr, size, len);
         read_burst(addr, size, len);
      end
      compare_memory();
      $display("errors: %0d testbench, %0d l2 model", errors, u_l2.errors);
      if (errors == 0 && u_l2.errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- sources.f
axi_line_pkg.sv
line_fsm_pkg.sv
write_gather.sv
read_scatter.sv
line_adapter.sv
tb_l2_model.sv
tb_line_adapter.sv
